//--- Makefile
# Verilator build and run for the microcontroller bridge subsystem

VERILATOR ?= verilator
TOP       ?= up_subsystem_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

check:
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
rtl/bridge_pkg.sv
rtl/io_bus_if.sv
rtl/up_bridge_fsm.sv
rtl/up_interface.sv
rtl/reg_bank_slave.sv
rtl/up_subsystem_top.sv
dv/up_subsystem_checker.sv
dv/up_subsystem_tb.sv

//--- dv/up_subsystem_checker.sv
// Handshake rule checker bound into the bridge datapath
`timescale 1ns/100ps
`default_nettype none

module up_subsystem_checker (
   input logic              clk,
   input logic              reset,
   input logic              up_start,
   input logic              up_ack,
   input logic              up_handshake_1,
   input logic              up_handshake_2,
   input logic              bus_handshake_1,
   input logic              bus_handshake_2,
   input logic              bus_rw,
   input bridge_pkg::byte_t bus_reg_address,
   input bridge_pkg::word_t bus_data_out
);

   // Bridge may only close a byte after the controller dropped its request
   assert property (@(posedge clk) disable iff (!reset)
      $fell(up_handshake_2) |-> !$past(up_handshake_1))
      else $error("up_handshake_2 fell while up_handshake_1 was still high");

   assert property (@(posedge clk) disable iff (!reset)
      $rose(bus_handshake_2) |-> bus_handshake_1)
      else $error("bus handshake_2 rose without handshake_1");

   // Request fields frozen for the whole bus cycle
   assert property (@(posedge clk) disable iff (!reset)
      bus_handshake_1 && $past(bus_handshake_1) |->
         $stable(bus_rw) && $stable(bus_reg_address) && $stable(bus_data_out))
      else $error("bus fields changed while handshake_1 was high");

   // Acknowledge only answers a start request
   assert property (@(posedge clk) disable iff (!reset)
      $rose(up_ack) |-> $past(up_start))
      else $error("up_ack rose without up_start");

   assert property (@(posedge clk) disable iff (!reset)
      $rose(up_handshake_2) |-> $past(up_handshake_1))
      else $error("up_handshake_2 rose without up_handshake_1");

endmodule

`default_nettype wire

//--- dv/up_subsystem_tb.sv
// Testbench for the bridge subsystem with a controller driver and a register file model
`timescale 1ns/100ps
`default_nettype none

module up_subsystem_tb;

   localparam int CLK_PERIOD     = 40;
   localparam int DRIVE_DELAY    = 2;
   localparam int RESET_CYCLES   = 8;
   localparam int NUM_RANDOM     = 300;
   localparam int HS_PER_TRANS   = bridge_pkg::NUM_IN_BYTES + bridge_pkg::NUM_OUT_BYTES;
   localparam int MAX_HS_CYCLES  = 20;
   localparam int TIMEOUT_CYCLES = NUM_RANDOM * HS_PER_TRANS * MAX_HS_CYCLES + 4000;

   logic              clk;
   logic              reset;
   logic              up_start;
   logic              up_handshake_1;
   logic              up_rw;
   logic              up_ack;
   logic              up_handshake_2;
   logic              up_data_oe;
   bridge_pkg::byte_t up_data_in;
   bridge_pkg::byte_t up_data_out;

   bridge_pkg::word_t model_regs  [bridge_pkg::NUM_REGS];
   bridge_pkg::byte_t reply_bytes [bridge_pkg::NUM_OUT_BYTES];
   integer            seed;
   int                error_count;
   int                cycle_count;

   up_subsystem_top u_up_subsystem_top (
      .clk            (clk),
      .reset          (reset),
      .up_start       (up_start),
      .up_handshake_1 (up_handshake_1),
      .up_rw          (up_rw),
      .up_ack         (up_ack),
      .up_handshake_2 (up_handshake_2),
      .up_data_oe     (up_data_oe),
      .up_data_in     (up_data_in),
      .up_data_out    (up_data_out)
   );

   bind up_interface up_subsystem_checker u_up_subsystem_checker (
      .clk             (clk),
      .reset           (reset),
      .up_start        (up_start),
      .up_ack          (up_ack),
      .up_handshake_1  (up_handshake_1),
      .up_handshake_2  (up_handshake_2),
      .bus_handshake_1 (bus.handshake_1),
      .bus_handshake_2 (bus.handshake_2),
      .bus_rw          (bus.rw),
      .bus_reg_address (bus.reg_address),
      .bus_data_out    (bus.data_out)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial cycle_count = 0;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic check_byte(input string name, input bridge_pkg::byte_t expected,
                             input bridge_pkg::byte_t actual);
      if (actual !== expected) begin
         error_count++;
         $display("error %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         error_count++;
         $display("error %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic next_edge();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic random_wait();
      int n;
      n = int'($unsigned($random(seed)) % 16);  // 0 to 15 cycles
      repeat (n) begin
         next_edge();
      end
   endtask

   task automatic wait_ack(input logic level);
      do begin
         next_edge();
      end while (up_ack !== level);
   endtask

   task automatic wait_hs2(input logic level);
      do begin
         next_edge();
      end while (up_handshake_2 !== level);
   endtask

   task automatic start_exchange();
      random_wait();
      up_start = 1'b1;
      wait_ack(1'b1);
      up_start = 1'b0;
      wait_ack(1'b0);
   endtask

   task automatic send_byte(input bridge_pkg::byte_t value);
      random_wait();
      up_rw          = 1'b1;
      up_data_in     = value;
      up_handshake_1 = 1'b1;
      wait_hs2(1'b1);
      check_bit("output enable on command byte", 1'b0, up_data_oe);
      up_handshake_1 = 1'b0;
      wait_hs2(1'b0);
   endtask

   task automatic receive_byte(output bridge_pkg::byte_t value);
      random_wait();
      up_rw          = 1'b0;
      up_handshake_1 = 1'b1;
      wait_hs2(1'b1);
      check_bit("output enable on reply byte", 1'b1, up_data_oe);
      value          = up_data_out;  // Valid while handshake_2 is high
      up_handshake_1 = 1'b0;
      wait_hs2(1'b0);
   endtask

   task automatic run_transaction(input bridge_pkg::byte_t cmd, input bridge_pkg::byte_t reg_num,
                                  input bridge_pkg::word_t data);
      bridge_pkg::byte_t cmd_bytes [bridge_pkg::NUM_IN_BYTES];
      cmd_bytes[bridge_pkg::CMD_BYTE]      = cmd;
      cmd_bytes[bridge_pkg::REG_BYTE]      = reg_num;
      cmd_bytes[bridge_pkg::DATA_BYTE]     = data[7:0];  // LSB first
      cmd_bytes[bridge_pkg::DATA_BYTE + 1] = data[15:8];
      cmd_bytes[bridge_pkg::DATA_BYTE + 2] = data[23:16];
      cmd_bytes[bridge_pkg::DATA_BYTE + 3] = data[31:24];
      start_exchange();
      for (bridge_pkg::count_t i = 0; i < bridge_pkg::count_t'(bridge_pkg::NUM_IN_BYTES); i++) begin
         send_byte(cmd_bytes[i]);
      end
      for (bridge_pkg::count_t i = 0; i < bridge_pkg::count_t'(bridge_pkg::NUM_OUT_BYTES); i++) begin
         receive_byte(reply_bytes[i]);
      end
   endtask

   // Slave rule: reply carries the register contents after the operation
   function automatic void model_expect(input bridge_pkg::byte_t cmd,
                                        input bridge_pkg::byte_t reg_num,
                                        input bridge_pkg::word_t data,
                                        output bridge_pkg::byte_t status,
                                        output bridge_pkg::word_t word);
      if (cmd[bridge_pkg::CMD_RESET_BIT]) begin
         model_regs = '{default: '0};
         status     = bridge_pkg::STATUS_RESET_DONE;
         word       = '0;
      end else if (cmd[bridge_pkg::CMD_RW_BIT]) begin
         status = bridge_pkg::STATUS_OK;
         word   = model_regs[reg_num[bridge_pkg::REG_ADDR_W-1:0]];
      end else begin
         model_regs[reg_num[bridge_pkg::REG_ADDR_W-1:0]] = data;
         status = bridge_pkg::STATUS_OK;
         word   = data;
      end
   endfunction

   task automatic check_transaction(input string name, input bridge_pkg::byte_t cmd,
                                    input bridge_pkg::byte_t reg_num,
                                    input bridge_pkg::word_t data);
      bridge_pkg::byte_t exp_status;
      bridge_pkg::word_t exp_word;
      run_transaction(cmd, reg_num, data);
      model_expect(cmd, reg_num, data, exp_status, exp_word);
      check_byte({name, " status"}, exp_status, reply_bytes[bridge_pkg::STATUS_BYTE]);
      check_byte({name, " data byte 0"}, exp_word[7:0],
                 reply_bytes[bridge_pkg::REPLY_DATA_BYTE]);
      check_byte({name, " data byte 1"}, exp_word[15:8],
                 reply_bytes[bridge_pkg::REPLY_DATA_BYTE + 1]);
      check_byte({name, " data byte 2"}, exp_word[23:16],
                 reply_bytes[bridge_pkg::REPLY_DATA_BYTE + 2]);
      check_byte({name, " data byte 3"}, exp_word[31:24],
                 reply_bytes[bridge_pkg::REPLY_DATA_BYTE + 3]);
   endtask

   initial begin
      bridge_pkg::byte_t cmd;
      bridge_pkg::byte_t reg_num;
      bridge_pkg::word_t data;
      seed           = 32'h0886_544f;
      error_count    = 0;
      reset          = 1'b0;
      up_start       = 1'b0;
      up_handshake_1 = 1'b0;
      up_rw          = 1'b1;
      up_data_in     = '0;
      model_regs     = '{default: '0};
      repeat (RESET_CYCLES) begin
         next_edge();
      end
      reset = 1'b1;
      next_edge();

      check_bit("reset up_ack", 1'b0, up_ack);
      check_bit("reset up_handshake_2", 1'b0, up_handshake_2);
      check_byte("reset up_data_out", 8'h00, up_data_out);
      check_bit("reset output enable", 1'b0, up_data_oe);

      check_transaction("write then read, write", 8'h00, 8'h03, 32'ha5c3_0f96);
      check_transaction("write then read, read", 8'h01, 8'h03, 32'h0000_0000);

      for (int i = 0; i < NUM_RANDOM; i++) begin
         cmd                           = bridge_pkg::byte_t'($random(seed));
         cmd[bridge_pkg::CMD_RESET_BIT] = 1'b0;
         reg_num                       = bridge_pkg::byte_t'($random(seed));  // Upper bits ignored
         data                          = bridge_pkg::word_t'($random(seed));
         check_transaction($sformatf("random %0d", i), cmd, reg_num, data);
      end

      check_transaction("soft reset", 8'h80, 8'h05, bridge_pkg::word_t'($random(seed)));
      for (int r = 0; r < bridge_pkg::NUM_REGS; r++) begin
         check_transaction($sformatf("read after soft reset, reg %0d", r), 8'h01,
                           bridge_pkg::byte_t'(r), 32'h0000_0000);
      end

      $display("errors: %0d", error_count);
      if (error_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/bridge_pkg.sv
// Bridge package with byte and word types, packet layout, command bits and status codes
`default_nettype none

package bridge_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [31:0] word_t;

   // Packet lengths in bytes
   localparam int NUM_IN_BYTES  = 6;
   localparam int NUM_OUT_BYTES = 5;

   localparam int CNT_W = $clog2(NUM_IN_BYTES + 1);
   typedef logic [CNT_W-1:0] count_t;

   // Command packet offsets
   localparam int CMD_BYTE  = 0;
   localparam int REG_BYTE  = 1;
   localparam int DATA_BYTE = 2;

   // Reply packet offsets
   localparam int STATUS_BYTE     = 0;
   localparam int REPLY_DATA_BYTE = 1;

   localparam int CMD_RW_BIT    = 0;  // 1 = read, 0 = write
   localparam int CMD_RESET_BIT = 7;

   localparam byte_t STATUS_OK         = 8'h01;
   localparam byte_t STATUS_RESET_DONE = 8'h80;

   // Slave register file
   localparam int NUM_REGS   = 16;
   localparam int REG_ADDR_W = 4;

endpackage

`default_nettype wire

//--- rtl/io_bus_if.sv
// Internal register bus with a four-phase request and completion handshake
`timescale 1ns/100ps
`default_nettype none

interface io_bus_if (
   input wire logic clk
);

   logic              handshake_1;  // Request
   logic              handshake_2;  // Completion
   logic              rw;
   bridge_pkg::byte_t reg_address;
   bridge_pkg::word_t data_out;     // Master to slave
   bridge_pkg::word_t data_in;      // Slave to master
   logic              soft_reset;

   modport master (
      input  clk, handshake_2, data_in,
      output handshake_1, rw, reg_address, data_out, soft_reset
   );

   modport slave (
      input  clk, handshake_1, rw, reg_address, data_out, soft_reset,
      output handshake_2, data_in
   );

endinterface

`default_nettype wire

//--- rtl/reg_bank_slave.sv
// Bus slave with sixteen 32-bit registers, level handshake and soft clear
`timescale 1ns/100ps
`default_nettype none

module reg_bank_slave (
   input  logic    clk,
   input  logic    reset,
   io_bus_if.slave bus
);

   bridge_pkg::word_t regs [bridge_pkg::NUM_REGS];

   logic [bridge_pkg::REG_ADDR_W-1:0] addr;
   logic                              start_op;

   assign addr     = bus.reg_address[bridge_pkg::REG_ADDR_W-1:0];
   assign start_op = bus.handshake_1 && !bus.handshake_2;

   always_ff @(posedge clk) begin
      if (!reset) begin
         bus.handshake_2 <= 1'b0;
         for (int i = 0; i < bridge_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (bus.soft_reset) begin
         for (int i = 0; i < bridge_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (start_op) begin
         if (!bus.rw) begin
            regs[addr] <= bus.data_out;
         end
         bus.handshake_2 <= 1'b1;
      end else if (!bus.handshake_1) begin
         bus.handshake_2 <= 1'b0;  // Close the four-phase cycle
      end
   end

   // Contents after the operation, so a write echoes its word
   always_ff @(posedge clk) begin
      if (start_op) begin
         bus.data_in <= bus.rw ? regs[addr] : bus.data_out;
      end
   end

endmodule

`default_nettype wire

//--- rtl/up_bridge_fsm.sv
// Bridge sequencer for the microcontroller handshakes, bus handshake and packet loops
`timescale 1ns/100ps
`default_nettype none

module up_bridge_fsm (
   input  logic clk,
   input  logic reset,
   input  logic up_start,
   input  logic up_handshake_1,
   output logic up_ack,
   output logic up_handshake_2,
   output logic bus_handshake_1,
   input  logic bus_handshake_2,
   input  logic soft_reset_req,
   input  logic counter_zero,
   output logic set_in_count,
   output logic set_out_count,
   output logic read_up_byte,
   output logic write_up_byte,
   output logic read_bus_word,
   output logic issue_soft_reset
);

   typedef enum logic [3:0] {
      IDLE,
      ACK,
      CMD_WAIT,
      CMD_HS,
      BUS_REQ,
      BUS_DONE,
      SOFT_RST,
      REPLY_WAIT,
      REPLY_HS
   } state_t;

   state_t state;
   state_t next_state;

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state    = state;
      set_in_count  = 1'b0;
      set_out_count = 1'b0;
      read_up_byte  = 1'b0;
      write_up_byte = 1'b0;
      read_bus_word = 1'b0;
      case (state)
         IDLE: begin
            if (up_start) begin
               next_state = ACK;
            end
         end
         ACK: begin
            if (!up_start) begin
               set_in_count = 1'b1;  // Arm the command loop
               next_state   = CMD_WAIT;
            end
         end
         CMD_WAIT: begin
            if (up_handshake_1) begin
               read_up_byte = 1'b1;
               next_state   = CMD_HS;
            end
         end
         CMD_HS: begin
            if (!up_handshake_1) begin
               if (!counter_zero) begin
                  next_state = CMD_WAIT;
               end else if (soft_reset_req) begin
                  next_state = SOFT_RST;
               end else begin
                  next_state = BUS_REQ;
               end
            end
         end
         BUS_REQ: begin
            if (bus_handshake_2) begin
               read_bus_word = 1'b1;  // Capture slave word
               next_state    = BUS_DONE;
            end
         end
         BUS_DONE: begin
            if (!bus_handshake_2) begin
               set_out_count = 1'b1;
               next_state    = REPLY_WAIT;
            end
         end
         SOFT_RST: begin
            set_out_count = 1'b1;
            next_state    = REPLY_WAIT;
         end
         REPLY_WAIT: begin
            if (up_handshake_1) begin
               write_up_byte = 1'b1;
               next_state    = REPLY_HS;
            end
         end
         REPLY_HS: begin
            if (!up_handshake_1) begin
               next_state = counter_zero ? IDLE : REPLY_WAIT;
            end
         end
         default: begin
            next_state = IDLE;
         end
      endcase
   end

   // Handshake levels decoded from the state register
   assign up_ack           = (state == ACK);
   assign up_handshake_2   = (state == CMD_HS) || (state == REPLY_HS);
   assign bus_handshake_1  = (state == BUS_REQ);
   assign issue_soft_reset = (state == SOFT_RST);  // Single cycle state

endmodule

`default_nettype wire

//--- rtl/up_interface.sv
// Microcontroller bridge datapath holding the command and reply packets and driving the bus
`timescale 1ns/100ps
`default_nettype none

module up_interface (
   input  logic              clk,
   input  logic              reset,
   io_bus_if.master          bus,
   input  logic              up_start,
   input  logic              up_handshake_1,
   input  logic              up_rw,
   output logic              up_ack,
   output logic              up_handshake_2,
   input  bridge_pkg::byte_t up_data_in,
   output bridge_pkg::byte_t up_data_out,
   output logic              up_data_oe
);

   logic set_in_count;
   logic set_out_count;
   logic read_up_byte;
   logic write_up_byte;
   logic read_bus_word;
   logic issue_soft_reset;
   logic counter_zero;
   logic soft_reset_req;

   bridge_pkg::count_t counter;    // Packet position
   bridge_pkg::count_t remaining;  // Bytes left in the loop
   bridge_pkg::byte_t  data_out;

   bridge_pkg::byte_t in_packet  [bridge_pkg::NUM_IN_BYTES];
   bridge_pkg::byte_t out_packet [bridge_pkg::NUM_OUT_BYTES];

   up_bridge_fsm u_up_bridge_fsm (
      .clk              (clk),
      .reset            (reset),
      .up_start         (up_start),
      .up_handshake_1   (up_handshake_1),
      .up_ack           (up_ack),
      .up_handshake_2   (up_handshake_2),
      .bus_handshake_1  (bus.handshake_1),
      .bus_handshake_2  (bus.handshake_2),
      .soft_reset_req   (soft_reset_req),
      .counter_zero     (counter_zero),
      .set_in_count     (set_in_count),
      .set_out_count    (set_out_count),
      .read_up_byte     (read_up_byte),
      .write_up_byte    (write_up_byte),
      .read_bus_word    (read_bus_word),
      .issue_soft_reset (issue_soft_reset)
   );

   always_ff @(posedge clk) begin
      if (!reset) begin
         counter   <= '0;
         remaining <= '0;
      end else if (set_in_count) begin
         counter   <= '0;
         remaining <= bridge_pkg::count_t'(bridge_pkg::NUM_IN_BYTES);
      end else if (set_out_count) begin
         counter   <= '0;
         remaining <= bridge_pkg::count_t'(bridge_pkg::NUM_OUT_BYTES);
      end else if (read_up_byte || write_up_byte) begin
         counter   <= counter + bridge_pkg::count_t'(1);
         remaining <= remaining - bridge_pkg::count_t'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         for (int i = 0; i < bridge_pkg::NUM_IN_BYTES; i++) begin
            in_packet[i] <= '0;
         end
         for (int i = 0; i < bridge_pkg::NUM_OUT_BYTES; i++) begin
            out_packet[i] <= '0;
         end
         data_out <= '0;
      end else begin
         if (read_up_byte) begin
            in_packet[counter] <= up_data_in;
         end
         if (read_bus_word) begin
            out_packet[bridge_pkg::STATUS_BYTE] <= bridge_pkg::STATUS_OK;
            for (int i = 0; i < 4; i++) begin
               out_packet[bridge_pkg::REPLY_DATA_BYTE + i] <= bus.data_in[8*i +: 8];
            end
         end else if (issue_soft_reset) begin
            out_packet[bridge_pkg::STATUS_BYTE] <= bridge_pkg::STATUS_RESET_DONE;
            for (int i = 0; i < 4; i++) begin
               out_packet[bridge_pkg::REPLY_DATA_BYTE + i] <= '0;
            end
         end
         if (write_up_byte) begin
            data_out <= out_packet[counter];  // Held while handshake_2 is high
         end
      end
   end

   assign counter_zero   = (remaining == '0);
   assign soft_reset_req = in_packet[bridge_pkg::CMD_BYTE][bridge_pkg::CMD_RESET_BIT];

   assign bus.rw          = in_packet[bridge_pkg::CMD_BYTE][bridge_pkg::CMD_RW_BIT];
   assign bus.reg_address = in_packet[bridge_pkg::REG_BYTE];
   assign bus.data_out    = {in_packet[bridge_pkg::DATA_BYTE + 3],
                             in_packet[bridge_pkg::DATA_BYTE + 2],
                             in_packet[bridge_pkg::DATA_BYTE + 1],
                             in_packet[bridge_pkg::DATA_BYTE]};
   assign bus.soft_reset  = issue_soft_reset;

   assign up_data_out = data_out;
   assign up_data_oe  = ~up_rw;  // Bridge drives the pad on reads

endmodule

`default_nettype wire

//--- rtl/up_subsystem_top.sv
// Subsystem top joining the microcontroller bridge and the register bank slave
`timescale 1ns/100ps
`default_nettype none

module up_subsystem_top (
   input  logic              clk,
   input  logic              reset,
   input  logic              up_start,
   input  logic              up_handshake_1,
   input  logic              up_rw,
   output logic              up_ack,
   output logic              up_handshake_2,
   output logic              up_data_oe,
   input  bridge_pkg::byte_t up_data_in,
   output bridge_pkg::byte_t up_data_out
);

   io_bus_if bus_if (
      .clk (clk)
   );

   up_interface u_up_interface (
      .clk            (clk),
      .reset          (reset),
      .bus            (bus_if.master),
      .up_start       (up_start),
      .up_handshake_1 (up_handshake_1),
      .up_rw          (up_rw),
      .up_ack         (up_ack),
      .up_handshake_2 (up_handshake_2),
      .up_data_in     (up_data_in),
      .up_data_out    (up_data_out),
      .up_data_oe     (up_data_oe)
   );

   reg_bank_slave u_reg_bank_slave (
      .clk   (clk),
      .reset (reset),
      .bus   (bus_if.slave)
   );

endmodule

`default_nettype wire
